// ==== common/core_pkg.sv ====
package core_pkg;

   typedef logic [31:0] xlen_t;
   typedef logic [4:0]  reg_idx_t;

   typedef enum logic [2:0] {
      ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_PASS_B
   } alu_op_e;

   typedef enum logic [2:0] {
      BR_NONE, BR_BEQ, BR_BNE, BR_BLT, BR_JAL, BR_JALR
   } branch_e;

   typedef enum logic [6:0] {
      OP_LUI    = 7'b0110111,
      OP_JAL    = 7'b1101111,
      OP_JALR   = 7'b1100111,
      OP_BRANCH = 7'b1100011,
      OP_LOAD   = 7'b0000011,
      OP_STORE  = 7'b0100011,
      OP_IMM    = 7'b0010011,
      OP_REG    = 7'b0110011
   } opcode_e;

   typedef struct packed {
      logic     valid;
      xlen_t    pc;
      reg_idx_t rs1;        // zero when the operand is not a register
      reg_idx_t rs2;
      xlen_t    a;
      xlen_t    b;          // rs2 value or immediate
      xlen_t    imm;
      xlen_t    store_data;
      reg_idx_t rd;
      logic     reg_we;
      logic     mem_re;
      logic     mem_we;
      alu_op_e  alu_op;
      branch_e  branch;
   } id_ex_t;

   typedef struct packed {
      logic     valid;
      xlen_t    result;     // alu value, address or link
      xlen_t    store_data;
      reg_idx_t rd;
      logic     reg_we;
      logic     mem_re;
      logic     mem_we;
   } ex_mem_t;

   typedef struct packed {
      logic     reg_we;
      reg_idx_t rd;
      xlen_t    data;
   } wb_t;

   localparam xlen_t UART_ADDR = 32'h8000_0000;

endpackage

// ==== hdl/instruction_fetch.sv ====
`timescale 1ns/1ps

module instruction_fetch import core_pkg::*; #(
   parameter int IMEM_DEPTH = 8
) (
   input  logic  clk,
   input  logic  rst_i,
   input  logic  run_i,
   input  logic  stall_i,
   input  logic  redirect_i,
   input  xlen_t target_i,
   input  xlen_t insn_addr_i,
   input  xlen_t insn_din_i,
   input  logic  insn_we_i,
   output xlen_t pc_o,
   output xlen_t insn_o,
   output logic  valid_o
);

   xlen_t imem [2**IMEM_DEPTH];
   xlen_t pc;

   // host load port, word addressed
   always_ff @(posedge clk) begin
      if (insn_we_i) begin
         imem[insn_addr_i[IMEM_DEPTH+1:2]] <= insn_din_i;
      end
   end

   always_ff @(posedge clk) begin
      if (rst_i) begin
         pc      <= '0;
         valid_o <= 1'b0;
      end else if (redirect_i) begin
         pc      <= target_i;
         valid_o <= 1'b0;  // squash the word in flight
      end else if (!stall_i) begin
         if (run_i) begin
            pc      <= pc + 32'd4;
            pc_o    <= pc;
            insn_o  <= imem[pc[IMEM_DEPTH+1:2]];
            valid_o <= 1'b1;
         end else begin
            valid_o <= 1'b0;  // pc holds
         end
      end
   end

endmodule

// ==== hdl/decoder.sv ====
`timescale 1ns/1ps

module decoder import core_pkg::*; (
   input  logic    clk,
   input  logic    rst_i,
   input  xlen_t   pc_i,
   input  xlen_t   insn_i,
   input  logic    valid_i,
   input  logic    flush_i,
   input  id_ex_t  ex_i,
   input  wb_t     wb_i,
   output logic    stall_o,
   output id_ex_t  id_ex_o
);

   xlen_t    regs [32];
   opcode_e  opcode;
   reg_idx_t rs1, rs2, rd;
   logic [2:0] funct3;
   xlen_t    imm_i, imm_s, imm_b, imm_u, imm_j;
   xlen_t    rs1_val, rs2_val;
   id_ex_t   dec;

   // read with bypass from the write in progress
   function automatic xlen_t rf_read(reg_idx_t idx, xlen_t stored, wb_t wb);
      if (idx == '0) return '0;
      if (wb.reg_we && wb.rd == idx) return wb.data;
      return stored;
   endfunction

   function automatic alu_op_e funct_to_alu(logic [2:0] f3, logic sub);
      case (f3)
         3'b000:  return sub ? ALU_SUB : ALU_ADD;
         3'b010:  return ALU_SLT;
         3'b100:  return ALU_XOR;
         3'b110:  return ALU_OR;
         3'b111:  return ALU_AND;
         default: return ALU_ADD;
      endcase
   endfunction

   assign opcode = opcode_e'(insn_i[6:0]);
   assign rd     = insn_i[11:7];
   assign funct3 = insn_i[14:12];
   assign rs1    = insn_i[19:15];
   assign rs2    = insn_i[24:20];

   assign imm_i = {{20{insn_i[31]}}, insn_i[31:20]};
   assign imm_s = {{20{insn_i[31]}}, insn_i[31:25], insn_i[11:7]};
   assign imm_b = {{19{insn_i[31]}}, insn_i[31], insn_i[7], insn_i[30:25], insn_i[11:8], 1'b0};
   assign imm_u = {insn_i[31:12], 12'b0};
   assign imm_j = {{11{insn_i[31]}}, insn_i[31], insn_i[19:12], insn_i[20], insn_i[30:21], 1'b0};

   assign rs1_val = rf_read(rs1, regs[rs1], wb_i);
   assign rs2_val = rf_read(rs2, regs[rs2], wb_i);

   always_comb begin
      dec        = '0;
      dec.valid  = valid_i;
      dec.pc     = pc_i;
      dec.alu_op = ALU_ADD;
      dec.branch = BR_NONE;
      case (opcode)
         OP_LUI: begin
            dec.rd = rd; dec.reg_we = 1'b1;
            dec.imm = imm_u; dec.b = imm_u; dec.alu_op = ALU_PASS_B;
         end
         OP_IMM: begin
            dec.rs1 = rs1; dec.a = rs1_val; dec.rd = rd; dec.reg_we = 1'b1;
            dec.imm = imm_i; dec.b = imm_i; dec.alu_op = funct_to_alu(funct3, 1'b0);
         end
         OP_REG: begin
            dec.rs1 = rs1; dec.a = rs1_val; dec.rs2 = rs2; dec.b = rs2_val;
            dec.rd = rd; dec.reg_we = 1'b1;
            dec.alu_op = funct_to_alu(funct3, insn_i[30]);
         end
         OP_LOAD: begin  // word only
            dec.rs1 = rs1; dec.a = rs1_val; dec.imm = imm_i; dec.b = imm_i;
            dec.rd = rd; dec.reg_we = 1'b1; dec.mem_re = 1'b1;
         end
         OP_STORE: begin
            dec.rs1 = rs1; dec.a = rs1_val; dec.imm = imm_s; dec.b = imm_s;
            dec.rs2 = rs2; dec.store_data = rs2_val; dec.mem_we = 1'b1;
         end
         OP_BRANCH: begin
            dec.rs1 = rs1; dec.a = rs1_val; dec.rs2 = rs2; dec.b = rs2_val;
            dec.imm = imm_b;
            case (funct3)
               3'b000:  dec.branch = BR_BEQ;
               3'b001:  dec.branch = BR_BNE;
               3'b100:  dec.branch = BR_BLT;
               default: dec.branch = BR_NONE;
            endcase
         end
         OP_JAL: begin
            dec.rd = rd; dec.reg_we = 1'b1; dec.imm = imm_j; dec.branch = BR_JAL;
         end
         OP_JALR: begin
            dec.rs1 = rs1; dec.a = rs1_val; dec.rd = rd; dec.reg_we = 1'b1;
            dec.imm = imm_i; dec.branch = BR_JALR;
         end
         default: ;  // treated as nop
      endcase
   end

   // load in EX feeding a source of this instruction
   assign stall_o = valid_i && ex_i.valid && ex_i.mem_re && ex_i.rd != '0 &&
                    (ex_i.rd == dec.rs1 || ex_i.rd == dec.rs2);

   always_ff @(posedge clk) begin
      if (wb_i.reg_we && wb_i.rd != '0) begin
         regs[wb_i.rd] <= wb_i.data;
      end
      if (rst_i || stall_o || flush_i) begin
         id_ex_o.valid <= 1'b0;  // bubble
      end else begin
         id_ex_o <= dec;
      end
   end

endmodule

// ==== hdl/data_forwarding.sv ====
`timescale 1ns/1ps

module data_forwarding import core_pkg::*; (
   input  id_ex_t  id_ex_i,
   input  ex_mem_t ex_mem_i,
   input  wb_t     wb_i,
   output xlen_t   op_a_o,
   output xlen_t   op_b_o,
   output xlen_t   store_data_o
);

   // newest producer wins, loads in MEM are covered by the load-use stall
   function automatic xlen_t pick(reg_idx_t idx, xlen_t dec_val, ex_mem_t mem, wb_t wb);
      if (idx == '0) return dec_val;
      if (mem.valid && mem.reg_we && !mem.mem_re && mem.rd == idx) return mem.result;
      if (wb.reg_we && wb.rd == idx) return wb.data;
      return dec_val;
   endfunction

   assign op_a_o = pick(id_ex_i.rs1, id_ex_i.a, ex_mem_i, wb_i);

   // stores carry rs2 for the data only, b is the offset
   assign op_b_o = id_ex_i.mem_we ? id_ex_i.b
                                  : pick(id_ex_i.rs2, id_ex_i.b, ex_mem_i, wb_i);

   assign store_data_o = pick(id_ex_i.rs2, id_ex_i.store_data, ex_mem_i, wb_i);

endmodule

// ==== hdl/executer.sv ====
`timescale 1ns/1ps

module executer import core_pkg::*; (
   input  logic    clk,
   input  logic    rst_i,
   input  id_ex_t  id_ex_i,
   input  xlen_t   op_a_i,
   input  xlen_t   op_b_i,
   input  xlen_t   store_data_i,
   output logic    redirect_o,
   output xlen_t   target_o,
   output logic    flush_o,
   output ex_mem_t ex_mem_o
);

   xlen_t   alu_res;
   logic    lt, eq, taken, is_jump;
   ex_mem_t nxt;

   assign lt      = $signed(op_a_i) < $signed(op_b_i);  // shared by slt and blt
   assign eq      = op_a_i == op_b_i;
   assign is_jump = id_ex_i.branch inside {BR_JAL, BR_JALR};

   always_comb begin
      case (id_ex_i.alu_op)
         ALU_ADD:    alu_res = op_a_i + op_b_i;
         ALU_SUB:    alu_res = op_a_i - op_b_i;
         ALU_AND:    alu_res = op_a_i & op_b_i;
         ALU_OR:     alu_res = op_a_i | op_b_i;
         ALU_XOR:    alu_res = op_a_i ^ op_b_i;
         ALU_SLT:    alu_res = {31'b0, lt};
         ALU_PASS_B: alu_res = op_b_i;
         default:    alu_res = '0;
      endcase
   end

   always_comb begin
      case (id_ex_i.branch)
         BR_BEQ:          taken = eq;
         BR_BNE:          taken = !eq;
         BR_BLT:          taken = lt;
         BR_JAL, BR_JALR: taken = 1'b1;
         default:         taken = 1'b0;
      endcase
   end

   assign target_o = (id_ex_i.branch == BR_JALR) ? ((op_a_i + id_ex_i.imm) & ~32'd1)
                                                 : id_ex_i.pc + id_ex_i.imm;
   assign redirect_o = id_ex_i.valid && taken;
   assign flush_o    = redirect_o;  // kills the instruction in decode

   always_comb begin
      nxt.valid      = id_ex_i.valid;
      nxt.result     = is_jump ? id_ex_i.pc + 32'd4 : alu_res;  // link value
      nxt.store_data = store_data_i;
      nxt.rd         = id_ex_i.rd;
      nxt.reg_we     = id_ex_i.reg_we;
      nxt.mem_re     = id_ex_i.mem_re;
      nxt.mem_we     = id_ex_i.mem_we;
   end

   always_ff @(posedge clk) begin
      if (rst_i) begin
         ex_mem_o.valid <= 1'b0;
      end else begin
         ex_mem_o <= nxt;
      end
   end

endmodule

// ==== hdl/data_memory.sv ====
`timescale 1ns/1ps

module data_memory import core_pkg::*; #(
   parameter int DMEM_DEPTH = 8
) (
   input  logic       clk,
   input  logic       rst_i,
   input  ex_mem_t    ex_mem_i,
   input  xlen_t      data_addr_i,
   input  xlen_t      data_din_i,
   input  logic       data_we_i,
   output wb_t        wb_o,
   output logic [7:0] uart_dout_o,
   output logic       uart_we_o
);

   xlen_t ram [2**DMEM_DEPTH];
   logic [DMEM_DEPTH-1:0] cpu_idx;
   logic [DMEM_DEPTH-1:0] host_idx;
   logic is_uart;
   logic store;
   logic uart_wr;

   assign cpu_idx  = ex_mem_i.result[DMEM_DEPTH+1:2];
   assign host_idx = data_addr_i[DMEM_DEPTH+1:2];
   assign is_uart  = ex_mem_i.result == UART_ADDR;
   assign store    = ex_mem_i.valid && ex_mem_i.mem_we;
   assign uart_wr  = store && is_uart;

   // single write port, host has priority
   always_ff @(posedge clk) begin
      if (data_we_i) begin
         ram[host_idx] <= data_din_i;
      end else if (store && !is_uart) begin
         ram[cpu_idx] <= ex_mem_i.store_data;
      end
   end

   always_ff @(posedge clk) begin
      wb_o.rd   <= ex_mem_i.rd;
      wb_o.data <= ex_mem_i.mem_re ? ram[cpu_idx] : ex_mem_i.result;
      if (uart_wr) begin
         uart_dout_o <= ex_mem_i.store_data[7:0];  // low byte only
      end
      if (rst_i) begin
         wb_o.reg_we <= 1'b0;
         uart_we_o   <= 1'b0;
      end else begin
         wb_o.reg_we <= ex_mem_i.valid && ex_mem_i.reg_we;
         uart_we_o   <= uart_wr;  // one pulse per store
      end
   end

endmodule

// ==== hdl/core.sv ====
`timescale 1ns/1ps

module core import core_pkg::*; #(
   parameter int IMEM_DEPTH = 8,
   parameter int DMEM_DEPTH = 8
) (
   input  logic       clk,
   input  logic       rst_i,
   input  logic       run_i,
   input  xlen_t      insn_addr_i,
   input  xlen_t      insn_din_i,
   input  logic       insn_we_i,
   input  xlen_t      data_addr_i,
   input  xlen_t      data_din_i,
   input  logic       data_we_i,
   output logic [7:0] uart_dout_o,
   output logic       uart_we_o
);

   xlen_t   pc_if, insn_if;
   logic    valid_if;
   logic    stall, redirect, flush;
   xlen_t   target;
   id_ex_t  id_ex;
   ex_mem_t ex_mem;
   wb_t     wb;
   xlen_t   op_a, op_b, store_data;

   instruction_fetch #(.IMEM_DEPTH(IMEM_DEPTH)) i_fetch (
      .clk(clk), .rst_i(rst_i), .run_i(run_i),
      .stall_i(stall),           // from decode
      .redirect_i(redirect),     // from EX
      .target_i(target),
      .insn_addr_i(insn_addr_i), .insn_din_i(insn_din_i), .insn_we_i(insn_we_i),
      .pc_o(pc_if), .insn_o(insn_if), .valid_o(valid_if)
   );

   decoder i_decoder (
      .clk(clk), .rst_i(rst_i),
      .pc_i(pc_if), .insn_i(insn_if), .valid_i(valid_if),
      .flush_i(flush),
      .ex_i(id_ex),              // own output, now in EX
      .wb_i(wb),
      .stall_o(stall), .id_ex_o(id_ex)
   );

   data_forwarding i_forwarding (
      .id_ex_i(id_ex), .ex_mem_i(ex_mem), .wb_i(wb),
      .op_a_o(op_a), .op_b_o(op_b), .store_data_o(store_data)
   );

   executer i_executer (
      .clk(clk), .rst_i(rst_i),
      .id_ex_i(id_ex), .op_a_i(op_a), .op_b_i(op_b), .store_data_i(store_data),
      .redirect_o(redirect), .target_o(target), .flush_o(flush),
      .ex_mem_o(ex_mem)
   );

   data_memory #(.DMEM_DEPTH(DMEM_DEPTH)) i_dmem (
      .clk(clk), .rst_i(rst_i),
      .ex_mem_i(ex_mem),
      .data_addr_i(data_addr_i), .data_din_i(data_din_i), .data_we_i(data_we_i),
      .wb_o(wb),
      .uart_dout_o(uart_dout_o), .uart_we_o(uart_we_o)
   );

endmodule

// ==== bench/core_tb.sv ====
`timescale 1ns/1ps

module core_tb import core_pkg::*; ();

   localparam int    TEST_CYCLES = 4000;  // the alu test needs about 2200
   localparam int    N_TESTS     = 6;
   localparam int    LIMIT       = N_TESTS * (TEST_CYCLES + 400);
   localparam xlen_t EMIT_ADDR   = 32'h300;  // word-to-uart subroutine

   logic       clk;
   logic       rst_i;
   logic       run_i;
   xlen_t      insn_addr_i, insn_din_i, data_addr_i, data_din_i;
   logic       insn_we_i, data_we_i;
   logic [7:0] uart_dout_o;
   logic       uart_we_o;

   xlen_t      code[$];  // program segment being assembled
   xlen_t      org;      // load address of that segment
   logic [7:0] rx[$];    // uart bytes in arrival order
   int         cycles;

   core #(.IMEM_DEPTH(8), .DMEM_DEPTH(8)) i_dut (
      .clk(clk), .rst_i(rst_i), .run_i(run_i),
      .insn_addr_i(insn_addr_i), .insn_din_i(insn_din_i), .insn_we_i(insn_we_i),
      .data_addr_i(data_addr_i), .data_din_i(data_din_i), .data_we_i(data_we_i),
      .uart_dout_o(uart_dout_o), .uart_we_o(uart_we_o)
   );

   always #4 clk = ~clk;

   always @(negedge clk) begin
      if (uart_we_o === 1'b1) rx.push_back(uart_dout_o);  // stable mid-cycle
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles > LIMIT) abort_run("timeout: simulation ran past its cycle limit");
   end

   task automatic abort_run(string msg);
      $display("%s", msg);
      $display("*** FAILED ***");
      $fatal(1);
   endtask

   // instruction encoders
   function automatic xlen_t r_type(logic [2:0] f3, logic alt, reg_idx_t rd,
                                    reg_idx_t rs1, reg_idx_t rs2);
      return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, OP_REG};
   endfunction

   function automatic xlen_t i_type(opcode_e op, logic [2:0] f3, reg_idx_t rd,
                                    reg_idx_t rs1, logic [11:0] imm);
      return {imm, rs1, f3, rd, op};
   endfunction

   function automatic xlen_t s_type(reg_idx_t rs1, reg_idx_t rs2, logic [11:0] imm);
      return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_STORE};
   endfunction

   function automatic xlen_t b_type(logic [2:0] f3, reg_idx_t rs1, reg_idx_t rs2,
                                    xlen_t off);
      return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
   endfunction

   function automatic xlen_t u_type(reg_idx_t rd, logic [19:0] imm);
      return {imm, rd, OP_LUI};
   endfunction

   function automatic xlen_t j_type(reg_idx_t rd, xlen_t off);
      return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
   endfunction

   function automatic xlen_t here();
      return org + 32'(code.size() * 4);
   endfunction

   task automatic start_code(xlen_t addr);
      org = addr;
      code.delete();
   endtask

   task automatic add_insn(xlen_t w);
      code.push_back(w);
   endtask

   // upper part rounded for the sign of the low part
   task automatic load_const(reg_idx_t rd, xlen_t value);
      xlen_t hi;
      hi = (value + 32'h800) >> 12;
      add_insn(u_type(rd, hi[19:0]));
      add_insn(i_type(OP_IMM, 3'b000, rd, rd, value[11:0]));
   endtask

   task automatic call_emit();
      add_insn(j_type(1, EMIT_ADDR - here()));
   endtask

   task automatic emit_reg(reg_idx_t src);
      add_insn(i_type(OP_IMM, 3'b000, 10, src, 12'h000));
      call_emit();
   endtask

   task automatic halt();
      add_insn(j_type(0, 32'h0));
   endtask

   task automatic load_code();
      for (int i = 0; i < code.size(); i++) begin
         @(posedge clk);
         #1;
         insn_addr_i = org + 32'(i * 4);
         insn_din_i  = code[i];
         insn_we_i   = 1'b1;
      end
      @(posedge clk);
      #1;
      insn_we_i = 1'b0;
   endtask

   task automatic write_data(xlen_t addr, xlen_t value);
      @(posedge clk);
      #1;
      data_addr_i = addr;
      data_din_i  = value;
      data_we_i   = 1'b1;
      @(posedge clk);
      #1;
      data_we_i = 1'b0;
   endtask

   // sends x10 as four bytes, low byte first; bits taken msb first with slt
   task automatic load_emit_routine();
      reg_idx_t acc;
      start_code(EMIT_ADDR);
      for (int b = 3; b >= 0; b--) begin
         acc = reg_idx_t'(11 + b);
         add_insn(i_type(OP_IMM, 3'b000, 5, 0, 12'd8));
         add_insn(i_type(OP_IMM, 3'b000, acc, 0, 12'd0));
         add_insn(r_type(3'b010, 1'b0, 6, 10, 0));    // top bit
         add_insn(r_type(3'b000, 1'b0, acc, acc, acc));
         add_insn(r_type(3'b000, 1'b0, acc, acc, 6));
         add_insn(r_type(3'b000, 1'b0, 10, 10, 10));  // shift left
         add_insn(i_type(OP_IMM, 3'b000, 5, 5, 12'hfff));
         add_insn(b_type(3'b001, 5, 0, -32'sd20));
      end
      for (int r = 11; r <= 14; r++) add_insn(s_type(31, reg_idx_t'(r), 12'h000));
      add_insn(i_type(OP_JALR, 3'b000, 0, 1, 12'h000));
      load_code();
   endtask

   task automatic pulse_reset();
      @(posedge clk);
      #1;
      rst_i = 1'b1;
      run_i = 1'b0;
      repeat (2) @(posedge clk);
      #1;
      rst_i = 1'b0;
   endtask

   task automatic reset_core();
      pulse_reset();
      rx.delete();
      load_emit_routine();
   endtask

   task automatic start_and_wait(int n, string name);
      int waited;
      waited = 0;
      @(posedge clk);
      #1;
      run_i = 1'b1;
      while (rx.size() < n && waited < TEST_CYCLES) begin
         @(posedge clk);
         waited++;
      end
      if (rx.size() < n)
         abort_run($sformatf("%s: only %0d of %0d uart bytes arrived", name, rx.size(), n));
      repeat (40) @(posedge clk);
      if (rx.size() != n)
         abort_run($sformatf("%s: %0d uart bytes arrived, expected %0d", name, rx.size(), n));
   endtask

   task automatic check_byte(string name, logic [7:0] got, logic [7:0] exp);
      if (got !== exp)
         abort_run($sformatf("error: uart_dout_o (%s) got %h expected %h", name, got, exp));
   endtask

   task automatic check_word(string name, xlen_t got, xlen_t exp);
      if (got !== exp)
         abort_run($sformatf("error: uart_dout_o word (%s) got %h expected %h", name, got, exp));
   endtask

   task automatic expect_byte(string name, logic [7:0] exp);
      check_byte(name, rx.pop_front(), exp);
   endtask

   task automatic expect_word(string name, xlen_t exp);
      xlen_t got;
      for (int k = 0; k < 4; k++) got[8*k +: 8] = rx.pop_front();
      check_word(name, got, exp);
   endtask

   task automatic test_alu();
      xlen_t a, b;
      a = $urandom();
      b = $urandom();
      reset_core();
      start_code(0);
      add_insn(u_type(31, 20'h80000));
      load_const(20, a);
      load_const(21, b);
      emit_reg(20);
      emit_reg(21);
      add_insn(r_type(3'b000, 1'b0, 10, 20, 21));
      call_emit();
      add_insn(r_type(3'b000, 1'b1, 10, 20, 21));
      call_emit();
      add_insn(r_type(3'b111, 1'b0, 10, 20, 21));
      call_emit();
      add_insn(r_type(3'b110, 1'b0, 10, 20, 21));
      call_emit();
      add_insn(r_type(3'b100, 1'b0, 10, 20, 21));
      call_emit();
      add_insn(r_type(3'b010, 1'b0, 10, 20, 21));
      call_emit();
      halt();
      load_code();
      start_and_wait(32, "alu");
      expect_word("lui/addi a", a);
      expect_word("lui/addi b", b);
      expect_word("add", a + b);
      expect_word("sub", a - b);
      expect_word("and", a & b);
      expect_word("or", a | b);
      expect_word("xor", a ^ b);
      expect_word("slt", ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
   endtask

   // producer to consumer distances 1 and 2, or 4 when spaced by nops
   task automatic add_chain(bit spaced);
      add_insn(r_type(3'b000, 1'b0, 3, 20, 21));
      if (spaced) repeat (3) add_insn(i_type(OP_IMM, 3'b000, 0, 0, 12'h000));
      add_insn(r_type(3'b100, 1'b0, 4, 3, 20));
      add_insn(i_type(OP_IMM, 3'b000, 8, 0, 12'd123));
      if (spaced) repeat (3) add_insn(i_type(OP_IMM, 3'b000, 0, 0, 12'h000));
      add_insn(r_type(3'b110, 1'b0, 10, 4, 21));
      if (spaced) repeat (3) add_insn(i_type(OP_IMM, 3'b000, 0, 0, 12'h000));
      add_insn(r_type(3'b000, 1'b0, 10, 10, 8));
      call_emit();
   endtask

   task automatic test_forwarding();
      xlen_t a, b, exp;
      a = $urandom();
      b = $urandom();
      exp = (((a + b) ^ a) | b) + 32'd123;
      reset_core();
      start_code(0);
      add_insn(u_type(31, 20'h80000));
      load_const(20, a);
      load_const(21, b);
      add_chain(1'b0);
      add_chain(1'b1);
      halt();
      load_code();
      start_and_wait(8, "forwarding");
      expect_word("back-to-back chain", exp);
      expect_word("nop-spaced chain", exp);
   endtask

   task automatic test_load();
      xlen_t d0, d1, b;
      d0 = $urandom();
      d1 = $urandom();
      b  = $urandom();
      reset_core();
      write_data(32'h40, d0);
      write_data(32'h44, d1);
      start_code(0);
      add_insn(u_type(31, 20'h80000));
      load_const(21, b);
      add_insn(i_type(OP_LOAD, 3'b010, 3, 0, 12'h040));
      add_insn(r_type(3'b000, 1'b0, 10, 3, 21));  // load-use
      call_emit();
      add_insn(i_type(OP_LOAD, 3'b010, 10, 0, 12'h044));
      call_emit();
      add_insn(s_type(0, 21, 12'h048));
      add_insn(i_type(OP_LOAD, 3'b010, 10, 0, 12'h048));
      call_emit();
      halt();
      load_code();
      start_and_wait(12, "load");
      expect_word("lw then add", d0 + b);
      expect_word("lw", d1);
      expect_word("sw then lw", b);
   endtask

   task automatic test_branch();
      xlen_t loop1, loop2;
      logic [7:0] seq[9];
      seq = '{8'd1, 8'd2, 8'd3, 8'd4, 8'd3, 8'd2, 8'd1, 8'd0, 8'h55};
      reset_core();
      start_code(0);
      add_insn(u_type(31, 20'h80000));
      add_insn(i_type(OP_IMM, 3'b000, 8, 0, 12'h0aa));  // marker
      add_insn(i_type(OP_IMM, 3'b000, 3, 0, 12'd0));
      add_insn(i_type(OP_IMM, 3'b000, 4, 0, 12'd4));
      loop1 = here();
      add_insn(i_type(OP_IMM, 3'b000, 3, 3, 12'd1));
      add_insn(s_type(31, 3, 12'h000));
      add_insn(b_type(3'b100, 3, 4, loop1 - here()));
      add_insn(b_type(3'b000, 0, 0, 32'd12));
      add_insn(s_type(31, 8, 12'h000));
      add_insn(s_type(31, 8, 12'h000));
      loop2 = here();
      add_insn(i_type(OP_IMM, 3'b000, 3, 3, 12'hfff));
      add_insn(s_type(31, 3, 12'h000));
      add_insn(b_type(3'b001, 3, 0, loop2 - here()));
      add_insn(b_type(3'b000, 0, 0, 32'd12));
      add_insn(s_type(31, 8, 12'h000));
      add_insn(s_type(31, 8, 12'h000));
      add_insn(i_type(OP_IMM, 3'b000, 9, 0, 12'h055));
      add_insn(s_type(31, 9, 12'h000));
      halt();
      load_code();
      start_and_wait(9, "branch");
      foreach (seq[i]) expect_byte($sformatf("branch byte %0d", i), seq[i]);
   endtask

   task automatic test_jump();
      xlen_t jal_pc, jalr_pc;
      reset_core();
      start_code(0);
      add_insn(u_type(31, 20'h80000));
      jal_pc = here();
      add_insn(j_type(1, 32'h200 - here()));
      add_insn(i_type(OP_IMM, 3'b000, 9, 0, 12'h05a));
      add_insn(s_type(31, 9, 12'h000));
      load_const(22, 32'h280);
      jalr_pc = here();
      add_insn(i_type(OP_JALR, 3'b000, 2, 22, 12'h001));  // bit 0 dropped
      add_insn(i_type(OP_IMM, 3'b000, 9, 0, 12'h06b));
      add_insn(s_type(31, 9, 12'h000));
      halt();
      load_code();
      start_code(32'h200);
      add_insn(i_type(OP_IMM, 3'b000, 15, 1, 12'h000));
      emit_reg(1);
      add_insn(i_type(OP_JALR, 3'b000, 0, 15, 12'h000));
      load_code();
      start_code(32'h280);
      add_insn(i_type(OP_IMM, 3'b000, 10, 2, 12'h000));
      call_emit();
      add_insn(i_type(OP_JALR, 3'b000, 0, 2, 12'h000));
      load_code();
      start_and_wait(10, "jump");
      expect_word("jal link", jal_pc + 32'd4);
      expect_byte("after jal return", 8'h5a);
      expect_word("jalr link", jalr_pc + 32'd4);
      expect_byte("after jalr return", 8'h6b);
   endtask

   task automatic test_run_control();
      reset_core();
      start_code(0);
      add_insn(u_type(31, 20'h80000));
      add_insn(i_type(OP_IMM, 3'b000, 9, 0, 12'h033));
      add_insn(s_type(31, 9, 12'h000));
      halt();
      load_code();
      pulse_reset();  // pc back to 0 with the program in place
      repeat (20) begin
         @(negedge clk);
         if (uart_we_o !== 1'b0) abort_run("run control: uart write seen while run_i was low");
      end
      start_and_wait(1, "run control");
      expect_byte("after run_i rises", 8'h33);
   endtask

   initial begin
      clk         = 1'b0;
      rst_i       = 1'b1;
      run_i       = 1'b0;
      insn_addr_i = '0;
      insn_din_i  = '0;
      insn_we_i   = 1'b0;
      data_addr_i = '0;
      data_din_i  = '0;
      data_we_i   = 1'b0;
      cycles      = 0;
      void'($urandom(98));
      test_alu();
      test_forwarding();
      test_load();
      test_branch();
      test_jump();
      test_run_control();
      $display("*** PASSED ***");
      $finish;
   end

endmodule

// ==== project.f ====
common/core_pkg.sv
hdl/instruction_fetch.sv
hdl/decoder.sv
hdl/data_forwarding.sv
hdl/executer.sv
hdl/data_memory.sv
hdl/core.sv
bench/core_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= core_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_STR  ?= *** PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -qF '$(PASS_STR)'

clean:
	rm -rf $(BUILD_DIR)
